// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import icache_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        inst_ready,
    output logic        inst_valid,
    output inst_out_t   inst,
    output fetch_req_t  req,
    input  fetch_rsp_t  rsp
);

    icache_addr_u pc;
    icache_addr_u req_addr;
    logic         req_active;
    logic         stale;
    logic         launch;
    logic         take;

    // Only with room in the output register
    assign launch = !req_active && !redirect_valid && (!inst_valid || inst_ready);
    assign take   = rsp.valid && !stale && !redirect_valid;

    assign req.valid = req_active || launch;
    assign req.addr  = req_active ? req_addr : pc;   // Held steady until rsp

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc.raw     <= RESET_PC;
            req_active <= 1'b0;
            stale      <= 1'b0;
            inst_valid <= 1'b0;
        end
        else
        begin
            if (launch)
                req_active <= 1'b1;
            else if (rsp.valid)
                req_active <= 1'b0;

            if (redirect_valid)
                stale <= req_active && !rsp.valid;   // Late answer gets dropped
            else if (rsp.valid)
                stale <= 1'b0;

            if (redirect_valid)
                pc.raw <= redirect_pc;
            else if (take)
                pc.raw <= pc.raw + 32'd4;

            if (redirect_valid)
                inst_valid <= 1'b0;
            else if (take)
                inst_valid <= 1'b1;
            else if (inst_ready)
                inst_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
            req_addr <= pc;
        if (take)
            inst <= '{pc: pc.raw, data: rsp.data};
    end

endmodule

// File: logic/icache.sv
`timescale 1ns/1ps

module icache
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  fetch_req_t req,
    output fetch_rsp_t rsp,
    output wb_req_t    wb_req,
    input  wb_rsp_t    wb_rsp
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL
    } state_t;

    state_t              state;
    icache_addr_u        lk_addr;
    logic [LINES-1:0]    line_valid;
    logic [TAG_BITS-1:0] tag_mem [LINES];
    logic [31:0]         data_mem [LINES];

    logic                rsp_valid;
    logic [31:0]         rsp_data;
    logic                wb_busy;
    icache_addr_u        wb_adr;

    logic                accept;
    logic                hit;
    logic                fill;

    // Requester still holds valid while the answer is out
    assign accept = (state == IDLE) && req.valid && !rsp_valid;
    assign hit    = line_valid[lk_addr.f.index] &&
                    (tag_mem[lk_addr.f.index] == lk_addr.f.tag);
    assign fill   = (state == REFILL) && wb_rsp.ack;

    assign rsp.valid  = rsp_valid;
    assign rsp.data   = rsp_data;
    assign wb_req.cyc = wb_busy;
    assign wb_req.stb = wb_busy;
    assign wb_req.adr = wb_adr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= IDLE;
            line_valid <= '0;
            rsp_valid  <= 1'b0;
            wb_busy    <= 1'b0;
        end
        else
        begin
            rsp_valid <= 1'b0;   // One-cycle pulse
            case (state)
                IDLE:
                begin
                    if (accept)
                        state <= LOOKUP;
                end
                LOOKUP:
                begin
                    if (hit)
                    begin
                        rsp_valid <= 1'b1;
                        state     <= IDLE;
                    end
                    else
                    begin
                        wb_busy <= 1'b1;
                        state   <= REFILL;
                    end
                end
                REFILL:
                begin
                    if (wb_rsp.ack)
                    begin
                        wb_busy                     <= 1'b0;
                        line_valid[lk_addr.f.index] <= 1'b1;
                        rsp_valid                   <= 1'b1;
                        state                       <= IDLE;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            lk_addr <= req.addr;

        if (state == LOOKUP && !hit)
            wb_adr.raw <= {lk_addr.raw[31:2], 2'b00};   // Word aligned read

        if (state == LOOKUP && hit)
            rsp_data <= data_mem[lk_addr.f.index];
        else if (fill)
            rsp_data <= wb_rsp.dat;

        if (fill)
        begin
            tag_mem[lk_addr.f.index]  <= lk_addr.f.tag;
            data_mem[lk_addr.f.index] <= wb_rsp.dat;
        end
    end

endmodule

// File: logic/icache_pkg.sv
package icache_pkg;

    localparam int INDEX_BITS = 4;
    localparam int TAG_BITS   = 26;
    localparam int LINES      = 1 << INDEX_BITS;

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [INDEX_BITS-1:0] index;
        logic [1:0]            offset;
    } addr_fields_t;

    // Same address word, byte view or cache lookup view
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } icache_addr_u;

    typedef struct packed {
        logic         valid;
        icache_addr_u addr;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } fetch_rsp_t;

    typedef struct packed {
        logic         cyc;
        logic         stb;
        icache_addr_u adr;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] data;
    } inst_out_t;

endpackage

// File: logic/icache_top.sv
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
#(
    parameter int          ROM_DEPTH = 64,
    parameter logic [31:0] RESET_PC  = 32'h0000_0000
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        inst_ready,
    output logic        inst_valid,
    output inst_out_t   inst
);

    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk           (clk),
        .rst           (rst),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .inst_ready    (inst_ready),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .req           (fetch_req),
        .rsp           (fetch_rsp)
    );

    icache u_cache (
        .clk   (clk),
        .rst   (rst),
        .req   (fetch_req),
        .rsp   (fetch_rsp),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

    inst_rom #(
        .ROM_DEPTH(ROM_DEPTH)
    ) u_rom (
        .clk   (clk),
        .rst   (rst),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

endmodule

// File: logic/inst_rom.sv
`timescale 1ns/1ps

module inst_rom
    import icache_pkg::*;
#(
    parameter int ROM_DEPTH = 64
)
(
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    logic [31:0] mem [ROM_DEPTH];
    logic [31:0] word_addr;
    logic        ack;
    logic [31:0] dat;

    initial
    begin
        $readmemh("logic/program.hex", mem);
    end

    // Image repeats across the address space
    assign word_addr = {2'b00, wb_req.adr.raw[31:2]} % ROM_DEPTH;

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = dat;

    always_ff @(posedge clk)
    begin
        if (rst)
            ack <= 1'b0;
        else
            ack <= wb_req.cyc && wb_req.stb && !ack;   // One wait state, one-cycle ack
    end

    always_ff @(posedge clk)
    begin
        if (wb_req.cyc && wb_req.stb && !ack)
            dat <= mem[word_addr];
    end

endmodule

// File: logic/program.hex
// One 32-bit instruction word per line, word address 0 first
00ff0040
01fe0141
02fd0242
03fc0343
04fb0444
05fa0545
06f90646
07f80747
08f70848
09f60949
0af50a4a
0bf40b4b
0cf30c4c
0df20d4d
0ef10e4e
0ff00f4f
10ef1050
11ee1151
12ed1252
13ec1353
14eb1454
15ea1555
16e91656
17e81757
18e71858
19e61959
1ae51a5a
1be41b5b
1ce31c5c
1de21d5d
1ee11e5e
1fe01f5f
20df2060
21de2161
22dd2262
23dc2363
24db2464
25da2565
26d92666
27d82767
28d72868
29d62969
2ad52a6a
2bd42b6b
2cd32c6c
2dd22d6d
2ed12e6e
2fd02f6f
30cf3070
31ce3171
32cd3272
33cc3373
34cb3474
35ca3575
36c93676
37c83777
38c73878
39c63979
3ac53a7a
3bc43b7b
3cc33c7c
3dc23d7d
3ec13e7e
3fc03f7f

// File: tb.f
logic/icache_pkg.sv
logic/fetch_unit.sv
logic/icache.sv
logic/inst_rom.sv
logic/icache_top.sv
tb/icache_asserts.sv
tb/icache_tb.sv

// File: tb/icache_asserts.sv
`timescale 1ns/1ps

module icache_asserts
    import icache_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input wb_req_t   wb_req,
    input wb_rsp_t   wb_rsp,
    input logic      inst_valid,
    input logic      inst_ready,
    input inst_out_t inst
);

    int fail_count = 0;

    stb_with_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_req.stb |-> wb_req.cyc)
    else
    begin
        fail_count++;
        $error("Wishbone stb without cyc");
    end

    ack_with_stb: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> wb_req.stb)
    else
    begin
        fail_count++;
        $error("Wishbone ack without stb");
    end

    // Address must hold until the slave answers
    adr_held: assert property (@(posedge clk) disable iff (rst)
        wb_req.stb && !wb_rsp.ack |=> $stable(wb_req.adr))
    else
    begin
        fail_count++;
        $error("Wishbone adr changed while waiting for ack");
    end

    inst_held: assert property (@(posedge clk) disable iff (rst)
        inst_valid && !inst_ready |=> $stable(inst))
    else
    begin
        fail_count++;
        $error("inst changed during a stall");
    end

endmodule

bind icache_top icache_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .inst_valid(inst_valid),
    .inst_ready(inst_ready),
    .inst      (inst)
);

// File: tb/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    localparam int          ROM_DEPTH  = 64;
    localparam logic [31:0] RESET_PC   = 32'h0000_0000;
    localparam int          NUM_CYCLES = 4000;
    localparam int          PERIOD     = 100;

    logic        clk;
    logic        rst;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        inst_ready;
    logic        inst_valid;
    inst_out_t   inst;

    logic [31:0] rom_model [ROM_DEPTH];
    integer      seed;
    int          errors;
    int          checks;
    int          assert_fails;
    int          xfers;
    int          cycle;
    int          last_xfer;
    logic [31:0] exp_pc;
    logic        measure_gaps;
    logic        after_redirect;
    logic        hold_pending;
    inst_out_t   held;

    icache_top #(
        .ROM_DEPTH(ROM_DEPTH),
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk           (clk),
        .rst           (rst),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .inst_ready    (inst_ready),
        .inst_valid    (inst_valid),
        .inst          (inst)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        $readmemh("logic/program.hex", rom_model);
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("[ERROR] t=%0t: %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] pc);
        return rom_model[(pc >> 2) % ROM_DEPTH];   // Image repeats every ROM_DEPTH words
    endfunction

    task automatic apply_redirect(input logic [31:0] pc);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(posedge clk);
        #10;
        redirect_valid = 1'b0;
    endtask

    task automatic wait_transfers(input int n);
        int target;
        target = xfers + n;
        wait (xfers >= target);
        #10;
    endtask

    // Reference model of the instruction stream
    always @(posedge clk)
    begin
        if (rst)
        begin
            exp_pc         = RESET_PC;
            hold_pending   = 1'b0;
            after_redirect = 1'b1;
        end
        else
        begin
            cycle++;
            if (hold_pending)
            begin
                check_value(inst_valid, 1'b1, "inst_valid dropped during stall");
                check_value(inst, held, "inst changed during stall");
            end
            if (redirect_valid)
            begin
                exp_pc         = redirect_pc;   // Wins over a same-cycle accept
                after_redirect = 1'b1;
            end
            else if (inst_valid && inst_ready)
            begin
                check_value(inst.pc, exp_pc, "instruction pc");
                check_value(inst.data, expected_word(exp_pc), "instruction data");
                if (measure_gaps && !after_redirect)
                    check_value(cycle - last_xfer, 3, "cycles between hits");
                after_redirect = 1'b0;
                last_xfer      = cycle;
                exp_pc         = exp_pc + 32'd4;
                xfers++;
            end
            hold_pending = inst_valid && !inst_ready && !redirect_valid;
            held         = inst;
        end
    end

    initial
    begin
        seed           = 83;
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = 32'h0;
        inst_ready     = 1'b0;
        measure_gaps   = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        check_value(inst_valid, 1'b0, "inst_valid after reset");

        repeat (NUM_CYCLES)
        begin
            inst_ready     = ({$random(seed)} % 100) < 75;
            redirect_valid = ({$random(seed)} % 100) < 3;
            redirect_pc    = ({$random(seed)} % 1024) * 4;   // Word aligned, below 4 KB
            @(posedge clk);
            #10;
        end

        inst_ready     = 1'b1;
        redirect_valid = 1'b0;
        apply_redirect(32'h0000_0200);   // Load one 8-word block
        wait_transfers(8);
        measure_gaps = 1'b1;
        apply_redirect(32'h0000_0200);   // Same block again, all hits
        wait_transfers(8);
        measure_gaps = 1'b0;
        apply_redirect(32'h0000_0640);   // Same indices, other tag, other words
        wait_transfers(4);

        assert_fails = UUT.u_asserts.fail_count;
        $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin
        repeat (NUM_CYCLES * 10) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", NUM_CYCLES * 10);
        $display("Done: errors found");
        $finish;
    end

endmodule
